// ==== commit_arbiter.sv ====
`timescale 1ns/1ps

module commit_arbiter (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                         [1:0]  lane_valid_i,
    input  cpu_types_pkg::instr_packet_t [1:0]  lane_ipacket_i,
    input  cpu_types_pkg::data_word_t    [1:0]  lane_result_i,
    input  cpu_types_pkg::instr_packet_t [1:0]  head_ipacket_i,
    input  cpu_types_pkg::data_word_t    [1:0]  head_result_i,
    input  logic                         [1:0]  empty_i,
    input  logic                         [1:0]  full_i,
    output logic                         [1:0]  push_o,
    output logic                         [1:0]  pull_o,
    output logic                                rob_write_o,
    output cpu_types_pkg::rob_tag_t             rob_tag_o,
    output commit_pkg::rob_entry_t              rob_entry_o,
    output logic                                stall_o
);

    import commit_pkg::*;

    arb_state_t   state_q;    // lane that owns the rob port.
    arb_state_t   state_d;
    commit_lane_t turn_lane;  // buffer served this cycle.
    logic [1:0]   bypass;     // incoming result goes straight to the rob.

    always_ff @(posedge clk_i) begin : state_reg
        if (!rst_n_i) begin
            state_q <= TURN_ITU;
        end else begin
            state_q <= state_d;
        end
    end : state_reg

    // **********************************************************************
    // round-robin selection and rob write
    // **********************************************************************

    always_comb begin : arbitrate
        state_d     = state_q;
        turn_lane   = LANE_ITU;
        pull_o      = '0;
        bypass      = '0;
        rob_write_o = 1'b0;
        rob_tag_o   = '0;
        rob_entry_o = '0;

        // hand the turn over as soon as the other buffer has work.
        case (state_q)
            TURN_ITU: begin
                turn_lane = LANE_ITU;
                if (!empty_i[LANE_LSU]) begin
                    state_d = TURN_LSU;
                end
            end
            TURN_LSU: begin
                turn_lane = LANE_LSU;
                if (!empty_i[LANE_ITU]) begin
                    state_d = TURN_ITU;
                end
            end
        endcase

        if (!empty_i[turn_lane]) begin
            pull_o[turn_lane] = 1'b1;  // oldest buffered result first.
            rob_write_o       = 1'b1;
            rob_tag_o         = head_ipacket_i[turn_lane].rob_tag;
            rob_entry_o       = packet_convert(head_ipacket_i[turn_lane],
                                               head_result_i[turn_lane]);
        end else if (lane_valid_i[turn_lane]) begin
            bypass[turn_lane] = 1'b1;  // empty buffer, skip storage.
            rob_write_o       = 1'b1;
            rob_tag_o         = lane_ipacket_i[turn_lane].rob_tag;
            rob_entry_o       = packet_convert(lane_ipacket_i[turn_lane],
                                               lane_result_i[turn_lane]);
        end
    end : arbitrate

    assign push_o  = lane_valid_i & ~bypass;  // store whatever is not bypassed.
    assign stall_o = |full_i;                 // upstream holds off on any full lane.

endmodule : commit_arbiter

// ==== commit_buffer.sv ====
`timescale 1ns/1ps

`include "commit_cfg.svh"

module commit_buffer #(
    parameter int DEPTH = `COMMIT_BUF_DEPTH  // must be a power of two.
) (
    input  logic                                         clk_i,
    input  logic                                         rst_n_i,
    input  logic                                         flush_i,
    input  logic                                         write_i,
    input  logic                                         read_i,
    input  cpu_types_pkg::data_word_t                    result_i,
    input  cpu_types_pkg::instr_packet_t                 ipacket_i,
    output cpu_types_pkg::data_word_t                    result_o,
    output cpu_types_pkg::instr_packet_t                 ipacket_o,
    input  logic                                         invalidate_i,
    input  cpu_types_pkg::reg_addr_t                     invalid_reg_i,
    input  cpu_types_pkg::reg_addr_t  [`FWD_PORTS-1:0]   forward_src_i,
    output cpu_types_pkg::data_word_t [`FWD_PORTS-1:0]   forward_result_o,
    output logic                      [`FWD_PORTS-1:0]   forward_valid_o,
    output logic                                         full_o,
    output logic                                         empty_o
);

    import cpu_types_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);

    data_word_t    result_q [DEPTH];  // buffered results.
    instr_packet_t packet_q [DEPTH];  // buffered packets.
    logic [DEPTH-1:0] fwd_valid_q;    // entry may still forward.
    logic [PTR_W-1:0] wr_ptr_q;       // next free slot.
    logic [PTR_W-1:0] rd_ptr_q;       // oldest entry.
    logic [PTR_W:0]   count_q;        // stored entries.

    // **********************************************************************
    // pointers, count and forward-valid bits
    // **********************************************************************

    always_ff @(posedge clk_i) begin : ctrl_reg
        if (!rst_n_i || flush_i) begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            count_q     <= '0;
            fwd_valid_q <= '0;  // a flush drops every pending result.
        end else begin
            // a newer result for the same register arrived on the other lane.
            for (int i = 0; i < DEPTH; i++) begin
                if (invalidate_i && (packet_q[i].reg_dest == invalid_reg_i)) begin
                    fwd_valid_q[i] <= 1'b0;
                end
            end
            if (write_i) begin
                wr_ptr_q              <= wr_ptr_q + 1'b1;  // wraps at depth.
                fwd_valid_q[wr_ptr_q] <= 1'b1;             // fresh entry forwards.
            end
            if (read_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({write_i, read_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // idle or push with pull.
            endcase
        end
    end : ctrl_reg

    always_ff @(posedge clk_i) begin : payload_reg
        if (write_i) begin
            result_q[wr_ptr_q] <= result_i;
            packet_q[wr_ptr_q] <= ipacket_i;
        end
    end : payload_reg

    assign result_o  = result_q[rd_ptr_q];  // head seen by the arbiter.
    assign ipacket_o = packet_q[rd_ptr_q];
    assign full_o    = (count_q == (PTR_W+1)'(DEPTH));
    assign empty_o   = (count_q == '0);

    // **********************************************************************
    // forwarding search
    // **********************************************************************

    // walks oldest to youngest, so the last hit left standing is the youngest.
    always_comb begin : forward_search
        logic [PTR_W-1:0] idx;
        idx = '0;
        for (int p = 0; p < `FWD_PORTS; p++) begin
            forward_result_o[p] = '0;
            forward_valid_o[p]  = 1'b0;
            for (int i = 0; i < DEPTH; i++) begin
                idx = rd_ptr_q + PTR_W'(i);
                if ((i < int'(count_q)) && fwd_valid_q[idx] &&
                    (packet_q[idx].reg_dest == forward_src_i[p])) begin
                    forward_result_o[p] = result_q[idx];
                    forward_valid_o[p]  = 1'b1;
                end
            end
        end
    end : forward_search

endmodule : commit_buffer

// ==== commit_cfg.svh ====
`ifndef COMMIT_CFG_SVH
`define COMMIT_CFG_SVH

// **********************************************************************
// commit stage sizing
// **********************************************************************

`define COMMIT_BUF_DEPTH 4   // entries per lane buffer, power of two.
`define ROB_TAG_W        6   // 64 reorder buffer slots.
`define REG_ADDR_W       5   // 32 architectural registers.
`define DATA_W           32  // integer datapath width.
`define FWD_PORTS        2   // register-read ports fed by forwarding.

`endif

// ==== commit_pkg.sv ====
package commit_pkg;

    import cpu_types_pkg::*;

    // **********************************************************************
    // commit stage types
    // **********************************************************************

    // the two result lanes, also the buffer index.
    typedef enum logic {
        LANE_ITU,  // itu and csr results.
        LANE_LSU   // lsu results.
    } commit_lane_t;

    // round-robin turn of the commit arbiter.
    typedef enum logic {
        TURN_ITU,
        TURN_LSU
    } arb_state_t;

    // what the reorder buffer stores per slot, 39 bits.
    typedef struct packed {
        data_word_t result;     // value to retire.
        reg_addr_t  reg_dest;   // register to update.
        logic       exception;  // exception pending on retire.
        logic       done;       // slot holds a finished result.
    } rob_entry_t;

    // builds a finished rob entry from a packet and its result.
    function automatic rob_entry_t packet_convert(
        input instr_packet_t packet,
        input data_word_t    result
    );
        rob_entry_t entry;
        entry.result    = result;
        entry.reg_dest  = packet.reg_dest;
        entry.exception = packet.exception;
        entry.done      = 1'b1;  // always complete once it reaches commit.
        return entry;
    endfunction : packet_convert

endpackage : commit_pkg

// ==== commit_stage.sv ====
`timescale 1ns/1ps

`include "commit_cfg.svh"

module commit_stage (
    input  logic                                          clk_i,
    input  logic                                          rst_n_i,
    input  logic                                          flush_i,
    input  cpu_types_pkg::data_word_t    [2:0]            result_i,
    input  cpu_types_pkg::instr_packet_t [2:0]            ipacket_i,
    input  logic                         [2:0]            data_valid_i,
    output logic                                          rob_write_o,
    output cpu_types_pkg::rob_tag_t                       rob_tag_o,
    output commit_pkg::rob_entry_t                        rob_entry_o,
    input  cpu_types_pkg::reg_addr_t     [`FWD_PORTS-1:0] forward_src_i,
    output cpu_types_pkg::data_word_t    [`FWD_PORTS-1:0] forward_data_o,
    output logic                         [`FWD_PORTS-1:0] forward_valid_o,
    output logic                                          stall_o
);

    import cpu_types_pkg::*;
    import commit_pkg::*;

    logic          [1:0] lane_valid;    // merged result strobes.
    instr_packet_t [1:0] lane_ipacket;
    data_word_t    [1:0] lane_result;
    instr_packet_t [1:0] head_ipacket;  // buffer heads.
    data_word_t    [1:0] head_result;
    logic          [1:0] buf_full;
    logic          [1:0] buf_empty;
    logic          [1:0] push;
    logic          [1:0] pull;
    data_word_t    [1:0][`FWD_PORTS-1:0] buf_fwd_result;
    logic          [1:0][`FWD_PORTS-1:0] buf_fwd_valid;

    // **********************************************************************
    // lane merge
    // **********************************************************************

    // idle units drive zero, so the or yields the single active csr or itu result.
    assign lane_valid[LANE_ITU]   = data_valid_i[ITU] | data_valid_i[CSR];
    assign lane_ipacket[LANE_ITU] = ipacket_i[ITU] | ipacket_i[CSR];
    assign lane_result[LANE_ITU]  = result_i[ITU] | result_i[CSR];
    assign lane_valid[LANE_LSU]   = data_valid_i[LSU];
    assign lane_ipacket[LANE_LSU] = ipacket_i[LSU];
    assign lane_result[LANE_LSU]  = result_i[LSU];

    // **********************************************************************
    // lane buffers, each invalidated by the other lane's arrivals
    // **********************************************************************

    commit_buffer #(.DEPTH(`COMMIT_BUF_DEPTH)) itu_buffer (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .write_i          (push[LANE_ITU]),
        .read_i           (pull[LANE_ITU]),
        .result_i         (lane_result[LANE_ITU]),
        .ipacket_i        (lane_ipacket[LANE_ITU]),
        .result_o         (head_result[LANE_ITU]),
        .ipacket_o        (head_ipacket[LANE_ITU]),
        .invalidate_i     (lane_valid[LANE_LSU]),
        .invalid_reg_i    (lane_ipacket[LANE_LSU].reg_dest),
        .forward_src_i    (forward_src_i),
        .forward_result_o (buf_fwd_result[LANE_ITU]),
        .forward_valid_o  (buf_fwd_valid[LANE_ITU]),
        .full_o           (buf_full[LANE_ITU]),
        .empty_o          (buf_empty[LANE_ITU])
    );

    commit_buffer #(.DEPTH(`COMMIT_BUF_DEPTH)) lsu_buffer (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .write_i          (push[LANE_LSU]),
        .read_i           (pull[LANE_LSU]),
        .result_i         (lane_result[LANE_LSU]),
        .ipacket_i        (lane_ipacket[LANE_LSU]),
        .result_o         (head_result[LANE_LSU]),
        .ipacket_o        (head_ipacket[LANE_LSU]),
        .invalidate_i     (lane_valid[LANE_ITU]),
        .invalid_reg_i    (lane_ipacket[LANE_ITU].reg_dest),
        .forward_src_i    (forward_src_i),
        .forward_result_o (buf_fwd_result[LANE_LSU]),
        .forward_valid_o  (buf_fwd_valid[LANE_LSU]),
        .full_o           (buf_full[LANE_LSU]),
        .empty_o          (buf_empty[LANE_LSU])
    );

    commit_arbiter arbiter (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .lane_valid_i   (lane_valid),
        .lane_ipacket_i (lane_ipacket),
        .lane_result_i  (lane_result),
        .head_ipacket_i (head_ipacket),
        .head_result_i  (head_result),
        .empty_i        (buf_empty),
        .full_i         (buf_full),
        .push_o         (push),
        .pull_o         (pull),
        .rob_write_o    (rob_write_o),
        .rob_tag_o      (rob_tag_o),
        .rob_entry_o    (rob_entry_o),
        .stall_o        (stall_o)
    );

    forward_select fwd_select (
        .forward_src_i        (forward_src_i),
        .lane_valid_i         (lane_valid),
        .lane_ipacket_i       (lane_ipacket),
        .lane_result_i        (lane_result),
        .buf_forward_result_i (buf_fwd_result),
        .buf_forward_valid_i  (buf_fwd_valid),
        .forward_data_o       (forward_data_o),
        .forward_valid_o      (forward_valid_o)
    );

endmodule : commit_stage

// ==== cpu_types_pkg.sv ====
`include "commit_cfg.svh"

package cpu_types_pkg;

    // **********************************************************************
    // basic datapath types
    // **********************************************************************

    typedef logic [`DATA_W-1:0]     data_word_t;  // one result word.
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;   // architectural register number.
    typedef logic [`ROB_TAG_W-1:0]  rob_tag_t;    // reorder buffer slot index.

    // execution units, also the index of the result inputs.
    typedef enum logic [1:0] {
        ITU,  // integer unit.
        LSU,  // load/store unit, variable latency.
        CSR   // csr unit, shares the itu lane.
    } exec_unit_t;

    // control info that travels with every result, 12 bits.
    typedef struct packed {
        rob_tag_t  rob_tag;    // destination slot in the rob.
        reg_addr_t reg_dest;   // destination register.
        logic      exception;  // raised by the execution unit.
    } instr_packet_t;

endpackage : cpu_types_pkg

// ==== filelist.f ====
+incdir+.
cpu_types_pkg.sv
commit_pkg.sv
commit_buffer.sv
commit_arbiter.sv
forward_select.sv
commit_stage.sv
tb_commit_stage.sv

// ==== forward_select.sv ====
`timescale 1ns/1ps

`include "commit_cfg.svh"

module forward_select (
    input  cpu_types_pkg::reg_addr_t     [`FWD_PORTS-1:0]       forward_src_i,
    input  logic                         [1:0]                  lane_valid_i,
    input  cpu_types_pkg::instr_packet_t [1:0]                  lane_ipacket_i,
    input  cpu_types_pkg::data_word_t    [1:0]                  lane_result_i,
    input  cpu_types_pkg::data_word_t    [1:0][`FWD_PORTS-1:0]  buf_forward_result_i,
    input  logic                         [1:0][`FWD_PORTS-1:0]  buf_forward_valid_i,
    output cpu_types_pkg::data_word_t    [`FWD_PORTS-1:0]       forward_data_o,
    output logic                         [`FWD_PORTS-1:0]       forward_valid_o
);

    import commit_pkg::*;

    logic [1:0][`FWD_PORTS-1:0] new_match;  // incoming result hits a port.

    always_comb begin : match_incoming
        for (int l = 0; l < 2; l++) begin
            for (int p = 0; p < `FWD_PORTS; p++) begin
                new_match[l][p] = lane_valid_i[l] &&
                                  (lane_ipacket_i[l].reg_dest == forward_src_i[p]);
            end
        end
    end : match_incoming

    // only one lane can hold a live copy of a register, so lane order is arbitrary.
    always_comb begin : select_source
        for (int p = 0; p < `FWD_PORTS; p++) begin
            forward_data_o[p]  = '0;
            forward_valid_o[p] = 1'b1;
            if (new_match[LANE_ITU][p]) begin
                forward_data_o[p] = lane_result_i[LANE_ITU];  // newest value wins.
            end else if (new_match[LANE_LSU][p]) begin
                forward_data_o[p] = lane_result_i[LANE_LSU];
            end else if (buf_forward_valid_i[LANE_ITU][p]) begin
                forward_data_o[p] = buf_forward_result_i[LANE_ITU][p];
            end else if (buf_forward_valid_i[LANE_LSU][p]) begin
                forward_data_o[p] = buf_forward_result_i[LANE_LSU][p];
            end else begin
                forward_valid_o[p] = 1'b0;  // no source holds this register.
            end
        end
    end : select_source

endmodule : forward_select

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the commit stage testbench with Verilator, runs it and scans the log.
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_commit_stage -f filelist.f > build.log 2>&1 \
    && ./obj_dir/Vtb_commit_stage > sim.log 2>&1 \
    || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "Test failed" sim.log \
    && { echo "FAIL: see sim.log"; exit 1; } \
    || { echo "PASS"; exit 0; }

// ==== tb_commit_stage.sv ====
`timescale 1ns/1ps

`include "commit_cfg.svh"

module tb_commit_stage;

    import cpu_types_pkg::*;
    import commit_pkg::*;

    localparam int CLK_PERIOD   = 100;  // ns.
    localparam int RESET_CYCLES = 16;
    localparam int DRAIN_CYCLES = 24;   // slack for the buffers to empty.
    localparam int V_NO = 0;            // unit valid codes, bit index is exec_unit_t.
    localparam int V_I  = 1;
    localparam int V_L  = 2;
    localparam int V_IL = 3;
    localparam int V_C  = 4;

    // one cycle of stimulus with the values expected before the next rising edge.
    typedef struct packed {
        logic       rnd;     // filler row, stimulus drawn at run time.
        logic [2:0] vld;
        logic       flush;
        logic [5:0] itag;    // itu or csr result.
        logic [4:0] idst;
        logic [5:0] ltag;    // lsu result.
        logic [4:0] ldst;
        logic [4:0] src0;
        logic [4:0] src1;
        logic       chk;     // compare the outputs below.
        logic [1:0] efv;
        logic [5:0] et0;     // tag whose data port 0 should return.
        logic [5:0] et1;
        logic       ewr;
        logic       estall;
    } row_t;

    typedef struct packed {
        rob_tag_t   tag;
        rob_entry_t entry;
    } rob_item_t;

    logic                                  clk_i;
    logic                                  rst_n_i;
    logic                                  flush_i;
    data_word_t    [2:0]                   result_i;
    instr_packet_t [2:0]                   ipacket_i;
    logic          [2:0]                   data_valid_i;
    logic                                  rob_write_o;
    rob_tag_t                              rob_tag_o;
    rob_entry_t                            rob_entry_o;
    reg_addr_t     [`FWD_PORTS-1:0]        forward_src_i;
    data_word_t    [`FWD_PORTS-1:0]        forward_data_o;
    logic          [`FWD_PORTS-1:0]        forward_valid_o;
    logic                                  stall_o;

    row_t       rows [$];
    rob_item_t  itu_q [$];                   // pending itu lane commits, oldest first.
    rob_item_t  lsu_q [$];
    data_word_t tag_data [2**`ROB_TAG_W];    // last result driven per tag.
    rob_tag_t   next_tag    = 6'd32;         // filler tags start above the directed ones.
    int         error_count = 0;
    int         check_count = 0;
    int         write_count = 0;
    int         drop_count  = 0;
    int         timeout_ns  = 0;

    commit_stage commit_stage_i (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .flush_i         (flush_i),
        .result_i        (result_i),
        .ipacket_i       (ipacket_i),
        .data_valid_i    (data_valid_i),
        .rob_write_o     (rob_write_o),
        .rob_tag_o       (rob_tag_o),
        .rob_entry_o     (rob_entry_o),
        .forward_src_i   (forward_src_i),
        .forward_data_o  (forward_data_o),
        .forward_valid_o (forward_valid_o),
        .stall_o         (stall_o)
    );

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #(CLK_PERIOD/2) clk_i = ~clk_i;
    end : clock_gen

    // **********************************************************************
    // stimulus table
    // **********************************************************************

    function automatic void push_row(
        input int vld, flush,
        input int itag, idst, ltag, ldst,
        input int src0, src1,
        input int chk, efv, et0, et1, ewr, estall
    );
        row_t r;
        r        = '0;
        r.vld    = 3'(vld);
        r.flush  = 1'(flush);
        r.itag   = 6'(itag);
        r.idst   = 5'(idst);
        r.ltag   = 6'(ltag);
        r.ldst   = 5'(ldst);
        r.src0   = 5'(src0);
        r.src1   = 5'(src1);
        r.chk    = 1'(chk);
        r.efv    = 2'(efv);
        r.et0    = 6'(et0);
        r.et1    = 6'(et1);
        r.ewr    = 1'(ewr);
        r.estall = 1'(estall);
        rows.push_back(r);
    endfunction : push_row

    function automatic void append_filler(input int count);
        row_t r;
        r     = '0;
        r.rnd = 1'b1;
        for (int i = 0; i < count; i++) begin
            rows.push_back(r);
        end
    endfunction : append_filler

    function automatic void build_table();
        // vld flush itag idst ltag ldst src0 src1 chk efv et0 et1 ewr stall
        push_row(V_NO, 0,  0,  0,  0,  0,  3,  4, 1, 0,  0,  0, 1'b0, 0);  // idle after reset.
        push_row(V_I,  0,  1,  3,  0,  0,  3,  4, 1, 1,  1,  0, 1, 0);  // itu bypass.
        push_row(V_L,  0,  0,  0,  2,  5,  5,  3, 1, 1,  2,  0, 0, 0);
        push_row(V_L,  0,  0,  0,  3,  5,  5,  6, 1, 1,  3,  0, 0, 0);
        push_row(V_NO, 0,  0,  0,  0,  0,  5,  7, 1, 1,  3,  0, 1, 0);  // youngest r5 wins.
        push_row(V_C,  0,  4,  5,  0,  0,  5,  8, 1, 1,  4,  0, 1, 0);  // csr on itu lane.
        push_row(V_NO, 0,  0,  0,  0,  0,  5,  8, 1, 1,  4,  0, 0, 0);
        push_row(V_NO, 0,  0,  0,  0,  0,  5,  8, 1, 1,  4,  0, 1, 0);
        push_row(V_IL, 0,  6, 10,  5,  9,  9, 10, 1, 3,  5,  6, 1, 0);
        push_row(V_I,  0,  7,  9,  0,  0,  9, 10, 1, 1,  7,  0, 1, 0);  // itu kills lsu r9.
        push_row(V_NO, 0,  0,  0,  0,  0,  9, 10, 1, 0,  0,  0, 1, 0);
        for (int i = 0; i < 7; i++) begin  // both lanes every cycle until itu fills.
            push_row(V_IL, 0, 8 + 2*i, 1, 9 + 2*i, 2, 1, 2, 1, 3, 8 + 2*i, 9 + 2*i, 1, 0);
        end
        push_row(V_NO, 0,  0,  0,  0,  0,  1,  2, 1, 3, 20, 21, 1, 1);  // itu buffer full.
        push_row(V_NO, 0,  0,  0,  0,  0,  1,  2, 1, 3, 20, 21, 1, 0);
        for (int i = 0; i < 5; i++) begin
            push_row(V_NO, 0, 0, 0, 0, 0, 1, 2, 0, 0, 0, 0, 0, 0);
        end
        push_row(V_NO, 0,  0,  0,  0,  0,  1,  2, 1, 0,  0,  0, 0, 0);  // drained.
        push_row(V_L,  0,  0,  0, 22,  4,  4,  6, 1, 1, 22,  0, 0, 0);
        push_row(V_L,  0,  0,  0, 23,  6,  4,  6, 1, 3, 22, 23, 0, 0);
        push_row(V_I,  0, 24,  7,  0,  0,  6,  7, 1, 3, 23, 24, 1, 0);
        push_row(V_NO, 1,  0,  0,  0,  0,  6,  7, 1, 3, 23, 24, 1, 0);  // flush drops 24.
        push_row(V_NO, 0,  0,  0,  0,  0,  6,  7, 1, 0,  0,  0, 0, 0);
        push_row(V_I,  0, 25,  7,  0,  0,  6,  7, 1, 2,  0, 25, 1, 0);
        append_filler(48);
        for (int i = 0; i < 10; i++) begin
            push_row(V_NO, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        end
        push_row(V_NO, 0,  0,  0,  0,  0,  0,  0, 1, 0,  0,  0, 0, 0);
    endfunction : build_table

    // **********************************************************************
    // driving
    // **********************************************************************

    function automatic data_word_t directed_data(input rob_tag_t tag);
        return {16'hC0DE, 4'h0, tag, ~tag};
    endfunction : directed_data

    task automatic drive_unit(
        input exec_unit_t unit,
        input rob_tag_t   tag,
        input reg_addr_t  dest,
        input data_word_t data,
        input logic       exc
    );
        instr_packet_t pkt;
        rob_item_t     item;
        pkt.rob_tag          = tag;
        pkt.reg_dest         = dest;
        pkt.exception        = exc;
        data_valid_i[unit]   = 1'b1;
        ipacket_i[unit]      = pkt;
        result_i[unit]       = data;
        tag_data[tag]        = data;
        item.tag             = tag;
        item.entry.result    = data;
        item.entry.reg_dest  = dest;
        item.entry.exception = exc;
        item.entry.done      = 1'b1;
        if (unit == LSU) begin
            lsu_q.push_back(item);
        end else begin
            itu_q.push_back(item);  // csr shares the itu lane.
        end
    endtask : drive_unit

    task automatic drive_filler();
        int unsigned pick;
        if (!stall_o) begin  // nothing is offered while a buffer is full.
            pick = $urandom_range(2, 0);
            if (pick != 0) begin
                drive_unit((pick == 1) ? ITU : CSR, next_tag,
                           reg_addr_t'($urandom_range(31, 0)), $urandom,
                           1'($urandom_range(1, 0)));
                next_tag++;
            end
            if ($urandom_range(1, 0) == 1) begin
                drive_unit(LSU, next_tag, reg_addr_t'($urandom_range(31, 0)), $urandom,
                           1'($urandom_range(1, 0)));
                next_tag++;
            end
        end
    endtask : drive_filler

    task automatic apply_row(input row_t r);
        data_valid_i     = '0;  // idle units drive zero.
        ipacket_i        = '0;
        result_i         = '0;
        flush_i          = r.flush;
        forward_src_i[0] = r.src0;
        forward_src_i[1] = r.src1;
        if (r.rnd) begin
            drive_filler();
        end else begin
            if (r.vld[ITU]) begin
                drive_unit(ITU, r.itag, r.idst, directed_data(r.itag), r.itag[0]);
            end
            if (r.vld[CSR]) begin
                drive_unit(CSR, r.itag, r.idst, directed_data(r.itag), r.itag[0]);
            end
            if (r.vld[LSU]) begin
                drive_unit(LSU, r.ltag, r.ldst, directed_data(r.ltag), r.ltag[0]);
            end
        end
    endtask : apply_row

    // **********************************************************************
    // checking
    // **********************************************************************

    task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask : compare

    task automatic verify_row(input row_t r);
        if (r.chk) begin
            compare("rob write", 64'(rob_write_o), 64'(r.ewr));
            compare("stall", 64'(stall_o), 64'(r.estall));
            compare("forward valid", 64'(forward_valid_o), 64'(r.efv));
            if (r.efv[0]) begin
                compare("forward data port 0", 64'(forward_data_o[0]), 64'(tag_data[r.et0]));
            end
            if (r.efv[1]) begin
                compare("forward data port 1", 64'(forward_data_o[1]), 64'(tag_data[r.et1]));
            end
        end
    endtask : verify_row

    // each write must be the oldest pending result of one lane.
    always @(posedge clk_i) begin : rob_checker
        rob_item_t item;
        logic      found;
        if (rst_n_i && rob_write_o) begin
            found = 1'b1;
            if ((itu_q.size() > 0) && (itu_q[0].tag == rob_tag_o)) begin
                item = itu_q.pop_front();
            end else if ((lsu_q.size() > 0) && (lsu_q[0].tag == rob_tag_o)) begin
                item = lsu_q.pop_front();
            end else begin
                found = 1'b0;
                error_count++;
                $display("Error at %0t ns: rob tag %0d is not the oldest pending result",
                         $time, rob_tag_o);
            end
            if (found) begin
                write_count++;
                compare("rob entry", 64'(rob_entry_o), 64'(item.entry));
            end
        end
        if (rst_n_i && flush_i) begin
            drop_count += itu_q.size() + lsu_q.size();  // buffered results are gone.
            itu_q.delete();
            lsu_q.delete();
        end
    end : rob_checker

    initial begin : watchdog
        wait (timeout_ns > 0);
        #(timeout_ns);
        $display("watchdog: the run did not finish within %0d ns", timeout_ns);
        $display("Test failed");
        $finish;
    end : watchdog

    initial begin : stimulus
        rst_n_i       = 1'b0;
        flush_i       = 1'b0;
        result_i      = '0;
        ipacket_i     = '0;
        data_valid_i  = '0;
        forward_src_i = '0;
        void'($urandom(32'h4710));
        build_table();
        timeout_ns = (RESET_CYCLES + rows.size() + DRAIN_CYCLES) * CLK_PERIOD;
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        foreach (rows[i]) begin
            @(negedge clk_i);
            apply_row(rows[i]);
            @(posedge clk_i);
            verify_row(rows[i]);
        end
        @(negedge clk_i);
        if ((itu_q.size() + lsu_q.size()) != 0) begin
            error_count++;
            $display("%0d accepted results never reached the rob", itu_q.size() + lsu_q.size());
        end
        $display("checks %0d, rob writes %0d, flushed %0d, errors %0d",
                 check_count, write_count, drop_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end : stimulus

endmodule : tb_commit_stage
